// File: rtl/soc_pkg.sv
/* bus widths, target enum and address map of the peripheral subsystem
   boot ROM image and debug hold-off length */

package soc_pkg;

  // --------------------
  // types
  // --------------------
  typedef logic [31:0] addr_t;     // byte address
  typedef logic [31:0] data_t;     // bus word
  typedef logic [7:0]  spm_idx_t;  // scratchpad word index

  typedef enum logic [1:0] {
    TGT_ROM   = 2'd0,
    TGT_SPM   = 2'd1,
    TGT_CLINT = 2'd2,
    TGT_NONE  = 2'd3
  } target_e;

  // --------------------
  // address map
  // --------------------
  localparam addr_t       ROM_BASE   = 32'h0001_0000;
  localparam int unsigned ROM_WORDS  = 16;
  localparam addr_t       SPM_BASE   = 32'h8000_0000;
  localparam int unsigned SPM_WORDS  = 256;
  localparam addr_t       CLINT_BASE = 32'h0200_0000;
  localparam int unsigned CLINT_SIZE = 16;  // bytes

  // CLINT register offsets
  localparam addr_t CLINT_MTIMECMP_OFS = 32'h0;
  localparam addr_t CLINT_MTIME_OFS    = 32'h4;
  localparam addr_t CLINT_MSIP_OFS     = 32'h8;

  // debug request stays masked this long after reset
  localparam int unsigned DBG_HOLD_CYCLES = 500;

  // boot code, jumps to the scratchpad after a short setup
  localparam data_t BOOT_IMAGE [ROM_WORDS] = '{
    32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0182_a283,
    32'h0002_8067, 32'h0000_0013, 32'h8000_0000, 32'h0000_0000,
    32'h3040_1073, 32'h0080_0093, 32'h3000_a073, 32'h1050_0073,
    32'hffdf_f06f, 32'h0000_0013, 32'hdead_beef, 32'hcafe_f00d
  };

endpackage

// File: rtl/addr_decode.sv
/* first pipeline stage
   address map lookup, registered target, offset and write data */

`timescale 1ns/100ps

module addr_decode import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    ndmreset_n,
  input  logic    req_i,
  input  addr_t   req_addr_i,
  input  logic    req_we_i,
  input  data_t   req_wdata_i,
  output logic    dec_valid_o,
  output target_e dec_target_o,
  output addr_t   dec_offset_o,
  output logic    dec_we_o,
  output data_t   dec_wdata_o
);

  addr_t   rom_ofs;
  addr_t   spm_ofs;
  addr_t   clint_ofs;
  target_e target;
  addr_t   offset;

  // offsets wrap below the base, so a single compare checks both ends
  assign rom_ofs   = req_addr_i - ROM_BASE;
  assign spm_ofs   = req_addr_i - SPM_BASE;
  assign clint_ofs = req_addr_i - CLINT_BASE;

  always_comb begin
    target = TGT_NONE;
    offset = '0;
    if (rom_ofs < addr_t'(ROM_WORDS * 4)) begin
      target = TGT_ROM;
      offset = rom_ofs;
    end else if (spm_ofs < addr_t'(SPM_WORDS * 4)) begin
      target = TGT_SPM;
      offset = spm_ofs;
    end else if (clint_ofs < addr_t'(CLINT_SIZE)) begin
      target = TGT_CLINT;
      offset = clint_ofs;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      dec_valid_o  <= 1'b0;
      dec_target_o <= TGT_NONE;
      dec_we_o     <= 1'b0;
    end else begin
      dec_valid_o <= req_i;
      if (req_i) begin
        dec_target_o <= target;
        dec_we_o     <= req_we_i;
      end
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      dec_offset_o <= offset;
      dec_wdata_o  <= req_wdata_i;
    end
  end

endmodule

// File: rtl/scratch_mem.sv
/* scratchpad word memory, single port, registered read */

`timescale 1ns/100ps

module scratch_mem import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     we_i,
  input  logic     re_i,
  input  spm_idx_t idx_i,
  input  data_t    wdata_i,
  output data_t    rdata_o
);

  data_t mem_q [SPM_WORDS];
  data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[idx_i] <= wdata_i;
    end
    if (re_i) begin
      rdata_q <= mem_q[idx_i];  // data valid the next cycle
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: rtl/clint_timer.sv
/* core-local interruptor
   rtc sync and divide, mtime, mtimecmp and msip registers, interrupts */

`timescale 1ns/100ps

module clint_timer import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  ndmreset_n,
  input  logic  rtc_i,
  input  logic  we_i,
  input  logic  re_i,
  input  addr_t offset_i,
  input  data_t wdata_i,
  output data_t rdata_o,
  output logic  timer_irq_o,
  output logic  ipi_o
);

  logic [2:0] rtc_sync_q;  // two sync stages plus one for edge detect
  logic       rtc_rise;
  logic       rtc_div_q;
  logic       mtime_tick;
  data_t      mtime_q;
  data_t      mtimecmp_q;
  logic       msip_q;
  data_t      rdata_q;

  // --------------------
  // rtc divide by two
  // --------------------
  assign rtc_rise   = rtc_sync_q[1] && !rtc_sync_q[2];
  assign mtime_tick = rtc_rise && rtc_div_q;  // every second rising edge

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
      if (rtc_rise) rtc_div_q <= !rtc_div_q;
    end
  end

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // keeps the timer interrupt low
      msip_q     <= 1'b0;
    end else begin
      if (mtime_tick) mtime_q <= mtime_q + 1'b1;
      // mtime is read only
      if (we_i && offset_i == CLINT_MTIMECMP_OFS) mtimecmp_q <= wdata_i;
      if (we_i && offset_i == CLINT_MSIP_OFS) msip_q <= wdata_i[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (re_i) begin
      case (offset_i)
        CLINT_MTIMECMP_OFS: rdata_q <= mtimecmp_q;
        CLINT_MTIME_OFS:    rdata_q <= mtime_q;
        CLINT_MSIP_OFS:     rdata_q <= data_t'(msip_q);
        default:            rdata_q <= '0;  // unused offset
      endcase
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign ipi_o       = msip_q;

endmodule

// File: rtl/periph_access.sv
/* second pipeline stage
   boot ROM lookup, strobes to scratchpad and CLINT, response select */

`timescale 1ns/100ps

module periph_access import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    ndmreset_n,
  input  logic    dec_valid_i,
  input  target_e dec_target_i,
  input  addr_t   dec_offset_i,
  input  logic    dec_we_i,
  input  data_t   dec_wdata_i,
  input  logic    rtc_i,
  output logic    rsp_valid_o,
  output data_t   rsp_rdata_o,
  output logic    rsp_err_o,
  output logic    timer_irq_o,
  output logic    ipi_o
);

  logic     spm_we;
  logic     spm_re;
  spm_idx_t spm_idx;
  data_t    spm_wdata;
  data_t    spm_rdata;
  logic     clint_we;
  logic     clint_re;
  addr_t    clint_offset;
  data_t    clint_wdata;
  data_t    clint_rdata;
  logic     rom_re;
  data_t    rom_rdata_q;
  logic     acc_err;
  logic     rsp_valid_q;
  logic     rsp_err_q;
  logic     rsp_read_q;
  target_e  rsp_target_q;

  // --------------------
  // dispatch
  // --------------------
  assign acc_err = dec_valid_i &&
                   (dec_target_i == TGT_NONE || (dec_target_i == TGT_ROM && dec_we_i));

  assign rom_re   = dec_valid_i && dec_target_i == TGT_ROM && !dec_we_i;
  assign spm_we   = dec_valid_i && dec_target_i == TGT_SPM && dec_we_i;
  assign spm_re   = dec_valid_i && dec_target_i == TGT_SPM && !dec_we_i;
  assign clint_we = dec_valid_i && dec_target_i == TGT_CLINT && dec_we_i;
  assign clint_re = dec_valid_i && dec_target_i == TGT_CLINT && !dec_we_i;

  assign spm_idx      = dec_offset_i[2 +: $bits(spm_idx_t)];  // word index
  assign spm_wdata    = dec_wdata_i;
  assign clint_offset = dec_offset_i;
  assign clint_wdata  = dec_wdata_i;

  // boot ROM, read in the same cycle as the other targets
  always_ff @(posedge clk_i) begin
    if (rom_re) rom_rdata_q <= BOOT_IMAGE[dec_offset_i[2 +: $clog2(ROM_WORDS)]];
  end

  scratch_mem i_scratch_mem (
    .clk_i   ( clk_i     ),
    .we_i    ( spm_we    ),
    .re_i    ( spm_re    ),
    .idx_i   ( spm_idx   ),
    .wdata_i ( spm_wdata ),
    .rdata_o ( spm_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i        ),
    .ndmreset_n  ( ndmreset_n   ),
    .rtc_i       ( rtc_i        ),
    .we_i        ( clint_we     ),
    .re_i        ( clint_re     ),
    .offset_i    ( clint_offset ),
    .wdata_i     ( clint_wdata  ),
    .rdata_o     ( clint_rdata  ),
    .timer_irq_o ( timer_irq_o  ),
    .ipi_o       ( ipi_o        )
  );

  // --------------------
  // response
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_q  <= 1'b0;
      rsp_err_q    <= 1'b0;
      rsp_read_q   <= 1'b0;
      rsp_target_q <= TGT_NONE;
    end else begin
      rsp_valid_q  <= dec_valid_i;
      rsp_err_q    <= acc_err;
      rsp_read_q   <= dec_valid_i && !dec_we_i;
      rsp_target_q <= dec_target_i;
    end
  end

  always_comb begin
    rsp_rdata_o = '0;  // writes and errors return zero
    if (rsp_read_q && !rsp_err_q) begin
      case (rsp_target_q)
        TGT_ROM:   rsp_rdata_o = rom_rdata_q;
        TGT_SPM:   rsp_rdata_o = spm_rdata;
        TGT_CLINT: rsp_rdata_o = clint_rdata;
        default:   rsp_rdata_o = '0;
      endcase
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_err_q;

endmodule

// File: rtl/debug_gate.sv
/* debug request hold-off after reset */

`timescale 1ns/100ps

module debug_gate import soc_pkg::*; (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [$clog2(DBG_HOLD_CYCLES+1)-1:0] hold_cnt_q;

  // boot code runs undisturbed until the count runs out
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      hold_cnt_q <= $bits(hold_cnt_q)'(DBG_HOLD_CYCLES);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (hold_cnt_q == '0) && debug_req_i;

endmodule

// File: rtl/soc_subsys_top.sv
/* peripheral subsystem top level
   decode stage, access stage and debug request gate */

`timescale 1ns/100ps

module soc_subsys_top import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  ndmreset_n,
  input  logic  req_i,
  input  addr_t req_addr_i,
  input  logic  req_we_i,
  input  data_t req_wdata_i,
  input  logic  rtc_i,
  input  logic  debug_req_i,
  output logic  rsp_valid_o,
  output data_t rsp_rdata_o,
  output logic  rsp_err_o,
  output logic  timer_irq_o,
  output logic  ipi_o,
  output logic  debug_req_o
);

  // decode to access stage
  logic    dec_valid;
  target_e dec_target;
  addr_t   dec_offset;
  logic    dec_we;
  data_t   dec_wdata;

  addr_decode i_addr_decode (
    .clk_i        ( clk_i       ),
    .ndmreset_n   ( ndmreset_n  ),
    .req_i        ( req_i       ),
    .req_addr_i   ( req_addr_i  ),
    .req_we_i     ( req_we_i    ),
    .req_wdata_i  ( req_wdata_i ),
    .dec_valid_o  ( dec_valid   ),
    .dec_target_o ( dec_target  ),
    .dec_offset_o ( dec_offset  ),
    .dec_we_o     ( dec_we      ),
    .dec_wdata_o  ( dec_wdata   )
  );

  periph_access i_periph_access (
    .clk_i        ( clk_i       ),
    .ndmreset_n   ( ndmreset_n  ),
    .dec_valid_i  ( dec_valid   ),
    .dec_target_i ( dec_target  ),
    .dec_offset_i ( dec_offset  ),
    .dec_we_i     ( dec_we      ),
    .dec_wdata_i  ( dec_wdata   ),
    .rtc_i        ( rtc_i       ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_rdata_o  ( rsp_rdata_o ),
    .rsp_err_o    ( rsp_err_o   ),
    .timer_irq_o  ( timer_irq_o ),
    .ipi_o        ( ipi_o       )
  );

  debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: dv/soc_subsys_assert.sv
/* concurrent checks bound into the subsystem top level
   response timing and data, interrupts, debug hold-off */

`timescale 1ns/100ps

module soc_subsys_assert import soc_pkg::*; (
  input logic  clk_i,
  input logic  ndmreset_n,
  input logic  req_i,
  input logic  rsp_valid_i,
  input data_t rsp_rdata_i,
  input logic  rsp_err_i,
  input logic  timer_irq_i,
  input logic  ipi_i,
  input logic  debug_req_in_i,
  input logic  debug_req_out_i,
  input logic  exp_valid_i,
  input data_t exp_rdata_i,
  input logic  exp_err_i,
  input logic  exp_chk_i,
  input logic  exp_mtime_i,
  input data_t exp_cmp_i,
  input logic  exp_ipi_i
);

  int unsigned fail_cnt = 0;
  int unsigned cyc_q;         // cycles since reset, saturating
  data_t       last_mtime_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cyc_q        <= 0;
      last_mtime_q <= '0;
    end else begin
      if (cyc_q < DBG_HOLD_CYCLES) cyc_q <= cyc_q + 1;
      if (rsp_valid_i && exp_mtime_i) last_mtime_q <= rsp_rdata_i;
    end
  end

  // --------------------
  // bus responses
  // --------------------
  rsp_latency: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_i |-> ##2 rsp_valid_i)
    else begin
      fail_cnt++;
      $error("a request got no response exactly two cycles later");
    end

  rsp_expected: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_valid_i |-> exp_valid_i)
    else begin
      fail_cnt++;
      $error("a response arrived with no request pending");
    end

  rsp_data: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_valid_i && exp_chk_i |-> rsp_rdata_i == exp_rdata_i)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t rsp_rdata_o expected %h actual %h", $time,
             $sampled(exp_rdata_i), $sampled(rsp_rdata_i));
    end

  rsp_error: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_valid_i |-> rsp_err_i == exp_err_i)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t rsp_err_o expected %b actual %b", $time,
             $sampled(exp_err_i), $sampled(rsp_err_i));
    end

  // --------------------
  // CLINT and debug
  // --------------------
  mtime_order: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_valid_i && exp_mtime_i |-> rsp_rdata_i >= last_mtime_q)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t mtime read expected at least %h actual %h", $time,
             $sampled(last_mtime_q), $sampled(rsp_rdata_i));
    end

  // mtime may step once between the read and its response
  timer_level: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_valid_i && exp_mtime_i |->
      (timer_irq_i == (rsp_rdata_i >= exp_cmp_i)) || (rsp_rdata_i + 32'd1 == exp_cmp_i))
    else begin
      fail_cnt++;
      $error("[FAIL] %0t timer_irq_o expected %b actual %b", $time,
             $sampled(rsp_rdata_i >= exp_cmp_i), $sampled(timer_irq_i));
    end

  ipi_level: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    ipi_i == exp_ipi_i)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t ipi_o expected %b actual %b", $time,
             $sampled(exp_ipi_i), $sampled(ipi_i));
    end

  debug_hold: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    debug_req_out_i == (cyc_q >= DBG_HOLD_CYCLES && debug_req_in_i))
    else begin
      fail_cnt++;
      $error("[FAIL] %0t debug_req_o expected %b actual %b", $time,
             $sampled(cyc_q >= DBG_HOLD_CYCLES && debug_req_in_i),
             $sampled(debug_req_out_i));
    end

endmodule

// File: dv/tb_soc_subsys.sv
/* testbench for the peripheral subsystem
   clock, reset, bus stimulus, expected response queue, timeout */

`timescale 1ns/100ps

module tb_soc_subsys import soc_pkg::*; ();

  localparam data_t       CMP_VAL = 32'd6;
  // hold-off, ~300 cycles of accesses and the timer wait, doubled for margin
  localparam int unsigned TIMEOUT_CYCLES = 2 * (DBG_HOLD_CYCLES + 300 + 32 * (CMP_VAL + 1));

  typedef struct packed {
    data_t rdata;
    data_t cmp;      // mtimecmp in force at an mtime read
    logic  err;
    logic  chk;      // compare read data
    logic  mtime;    // mtime read, checked for order
    logic  ipi_upd;
    logic  ipi_val;
  } exp_t;

  logic  clk_i;
  logic  ndmreset_n;
  logic  req_i;
  addr_t req_addr_i;
  logic  req_we_i;
  data_t req_wdata_i;
  logic  rtc_i;
  logic  debug_req_i;
  logic  rsp_valid_o;
  data_t rsp_rdata_o;
  logic  rsp_err_o;
  logic  timer_irq_o;
  logic  ipi_o;
  logic  debug_req_o;

  // expected response, presented to the checker
  logic  exp_valid;
  data_t exp_rdata;
  logic  exp_err;
  logic  exp_chk;
  logic  exp_mtime;
  data_t exp_cmp;
  logic  exp_ipi;

  exp_t        exp_q [$];
  exp_t        head;
  data_t       spm_model [SPM_WORDS];
  data_t       cmp_model;
  logic        msip_model;
  logic [31:0] rng;
  addr_t       spm_addr [16];
  int unsigned cyc;
  int unsigned errors;
  int unsigned total;

  soc_subsys_top dut0 (.*);

  bind soc_subsys_top soc_subsys_assert u_assert (
    .clk_i           ( clk_i                   ),
    .ndmreset_n      ( ndmreset_n              ),
    .req_i           ( req_i                   ),
    .rsp_valid_i     ( rsp_valid_o             ),
    .rsp_rdata_i     ( rsp_rdata_o             ),
    .rsp_err_i       ( rsp_err_o               ),
    .timer_irq_i     ( timer_irq_o             ),
    .ipi_i           ( ipi_o                   ),
    .debug_req_in_i  ( debug_req_i             ),
    .debug_req_out_i ( debug_req_o             ),
    .exp_valid_i     ( tb_soc_subsys.exp_valid ),
    .exp_rdata_i     ( tb_soc_subsys.exp_rdata ),
    .exp_err_i       ( tb_soc_subsys.exp_err   ),
    .exp_chk_i       ( tb_soc_subsys.exp_chk   ),
    .exp_mtime_i     ( tb_soc_subsys.exp_mtime ),
    .exp_cmp_i       ( tb_soc_subsys.exp_cmp   ),
    .exp_ipi_i       ( tb_soc_subsys.exp_ipi   )
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // --------------------
  // clocks and timeout
  // --------------------
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    rtc_i = 1'b0;
    forever begin
      repeat (8) @(posedge clk_i);
      #1 rtc_i = ~rtc_i;
    end
  end

  always @(posedge clk_i) begin
    cyc++;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cyc);
      $display("TEST FAILED");
      $finish;
    end
  end

  // pops the expected entry in the cycle its response is on the bus
  always @(posedge clk_i) begin
    #1;
    exp_valid = 1'b0;
    if (rsp_valid_o && exp_q.size() > 0) begin
      head      = exp_q.pop_front();
      exp_valid = 1'b1;
      exp_rdata = head.rdata;
      exp_err   = head.err;
      exp_chk   = head.chk;
      exp_mtime = head.mtime;
      exp_cmp   = head.cmp;
      if (head.ipi_upd) exp_ipi = head.ipi_val;
    end
  end

  // --------------------
  // stimulus
  // --------------------
  // one request per call, predicted from the address map and response rule
  task automatic issue(input addr_t addr, input logic we, input data_t wdata);
    exp_t  e;
    addr_t ofs;
    e = '0;
    e.chk = 1'b1;
    if (addr >= ROM_BASE && addr < ROM_BASE + ROM_WORDS * 4) begin
      if (we) e.err = 1'b1;
      else e.rdata = BOOT_IMAGE[(addr - ROM_BASE) >> 2];
    end else if (addr >= SPM_BASE && addr < SPM_BASE + SPM_WORDS * 4) begin
      if (we) spm_model[(addr - SPM_BASE) >> 2] = wdata;
      else e.rdata = spm_model[(addr - SPM_BASE) >> 2];
    end else if (addr >= CLINT_BASE && addr < CLINT_BASE + CLINT_SIZE) begin
      ofs = addr - CLINT_BASE;
      if (we) begin
        if (ofs == CLINT_MTIMECMP_OFS) cmp_model = wdata;
        if (ofs == CLINT_MSIP_OFS) begin
          msip_model = wdata[0];
          e.ipi_upd  = 1'b1;
          e.ipi_val  = wdata[0];
        end
      end else if (ofs == CLINT_MTIME_OFS) begin
        e.chk   = 1'b0;
        e.mtime = 1'b1;
        e.cmp   = cmp_model;
      end else if (ofs == CLINT_MTIMECMP_OFS) begin
        e.rdata = cmp_model;
      end else if (ofs == CLINT_MSIP_OFS) begin
        e.rdata = data_t'(msip_model);
      end
    end else begin
      e.err = 1'b1;  // unmapped
    end
    exp_q.push_back(e);
    req_i       = 1'b1;
    req_addr_i  = addr;
    req_we_i    = we;
    req_wdata_i = wdata;
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle(input int unsigned n);
    req_i    = 1'b0;
    req_we_i = 1'b0;
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  initial begin
    ndmreset_n  = 1'b0;
    req_i       = 1'b0;
    req_addr_i  = '0;
    req_we_i    = 1'b0;
    req_wdata_i = '0;
    debug_req_i = 1'b1;  // held high through the hold-off
    exp_valid   = 1'b0;
    exp_rdata   = '0;
    exp_err     = 1'b0;
    exp_chk     = 1'b0;
    exp_mtime   = 1'b0;
    exp_cmp     = '0;
    exp_ipi     = 1'b0;
    cmp_model   = '1;
    msip_model  = 1'b0;
    rng         = 32'd23;
    cyc         = 0;
    errors      = 0;
    repeat (5) @(posedge clk_i);
    #1 ndmreset_n = 1'b1;
    idle(2);

    // timer interrupt, then software interrupt
    issue(CLINT_BASE + CLINT_MTIMECMP_OFS, 1'b0, '0);
    issue(CLINT_BASE + CLINT_MTIMECMP_OFS, 1'b1, CMP_VAL);
    issue(CLINT_BASE + CLINT_MTIMECMP_OFS, 1'b0, '0);
    issue(CLINT_BASE + 32'hc, 1'b0, '0);  // unused offset
    while (!timer_irq_o) begin
      issue(CLINT_BASE + CLINT_MTIME_OFS, 1'b0, '0);
      idle(7);
    end
    issue(CLINT_BASE + CLINT_MTIME_OFS, 1'b0, '0);
    issue(CLINT_BASE + CLINT_MSIP_OFS, 1'b1, 32'h1);
    issue(CLINT_BASE + CLINT_MSIP_OFS, 1'b0, '0);
    idle(3);
    issue(CLINT_BASE + CLINT_MSIP_OFS, 1'b1, 32'h0);
    issue(CLINT_BASE + CLINT_MSIP_OFS, 1'b0, '0);
    idle(3);

    // all ROM words, back to back
    for (int i = 0; i < ROM_WORDS; i++) issue(ROM_BASE + 4 * i, 1'b0, '0);
    idle(2);

    // random scratchpad writes, then reads of the same words
    for (int i = 0; i < 16; i++) begin
      rng = xorshift(rng);
      spm_addr[i] = SPM_BASE + {rng[7:0], 2'b00};
      rng = xorshift(rng);
      issue(spm_addr[i], 1'b1, rng);
    end
    for (int i = 0; i < 16; i++) issue(spm_addr[i], 1'b0, '0);
    idle(2);

    // error responses
    issue(ROM_BASE + 32'h8, 1'b1, 32'h1234_5678);
    issue(32'h0000_0000, 1'b0, '0);
    issue(ROM_BASE + ROM_WORDS * 4, 1'b0, '0);
    issue(SPM_BASE + SPM_WORDS * 4, 1'b1, 32'h5a5a_5a5a);
    issue(CLINT_BASE + CLINT_SIZE, 1'b0, '0);
    issue(32'hffff_fff0, 1'b0, '0);
    idle(4);

    // debug request once the hold-off has run out
    while (cyc < DBG_HOLD_CYCLES + 20) idle(1);
    debug_req_i = 1'b0;
    idle(5);
    debug_req_i = 1'b1;
    idle(5);
    debug_req_i = 1'b0;
    idle(4);

    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected responses never arrived", exp_q.size());
    end
    total = errors + dut0.u_assert.fail_cnt;
    $display("errors: %0d from assertions, %0d from the testbench",
             dut0.u_assert.fail_cnt, errors);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
rtl/soc_pkg.sv
rtl/addr_decode.sv
rtl/scratch_mem.sv
rtl/clint_timer.sv
rtl/periph_access.sv
rtl/debug_gate.sv
rtl/soc_subsys_top.sv
dv/soc_subsys_assert.sv
dv/tb_soc_subsys.sv

// File: Bender.yml
package:
  name: soc_subsys

sources:
  - rtl/soc_pkg.sv
  - rtl/addr_decode.sv
  - rtl/scratch_mem.sv
  - rtl/clint_timer.sv
  - rtl/periph_access.sv
  - rtl/debug_gate.sv
  - rtl/soc_subsys_top.sv
  - target: test
    files:
      - dv/soc_subsys_assert.sv
      - dv/tb_soc_subsys.sv
